// ==== src/ifu_pkg.sv ====
`default_nettype none

package ifu_pkg;

  // byte address and word tag widths
  localparam int ADDR_W      = 32;
  localparam int WORD_ADDR_W = 30;
  localparam int HALF_W      = 16;

  // low opcode bits of a 32-bit instruction
  // any other value means compressed
  localparam logic [1:0] FULL_OPC = 2'b11;

  // one fetched word, seen whole or as two halfwords
  // half[0] is the low halfword
  typedef union packed {
    logic [2*HALF_W-1:0]    word;
    logic [1:0][HALF_W-1:0] half;
  } fetch_word_u;

  // top-level parameter defaults
  localparam logic [ADDR_W-1:0] DEF_RESET_ADDR     = 32'h0000_0000;
  localparam int                DEF_PREFETCH_NUM   = 2;
  localparam int                DEF_INFLIGHT_DEPTH = 2;
  localparam int                DEF_LINE_DEPTH     = 2;

endpackage

`default_nettype wire

// ==== src/pc_sequencer.sv ====
`default_nettype none

module pc_sequencer #(
  parameter logic [ifu_pkg::ADDR_W-1:0] RESET_ADDR = ifu_pkg::DEF_RESET_ADDR
) (
  input  wire logic                         clk,
  input  wire logic                         rest,
  input  wire logic                         jump_en,
  input  wire logic [ifu_pkg::ADDR_W-1:0]   jump_addr,
  input  wire logic                         instr_ok,
  input  wire ifu_pkg::fetch_word_u         instr,
  input  wire logic                         issue_ready,
  output logic      [ifu_pkg::ADDR_W-1:0]   pc,
  output logic      [ifu_pkg::ADDR_W-1:0]   next_pc,
  output logic                              issue_valid,
  output logic      [2*ifu_pkg::HALF_W-1:0] issue_instr,
  output logic      [ifu_pkg::ADDR_W-1:0]   issue_pc
);

  logic       load;
  logic [2:0] step;

  // take a new instruction when the slot is empty or drains now
  // a jump blocks the load
  assign load = instr_ok && !jump_en && (!issue_valid || issue_ready);

  // 4 bytes for a full opcode, 2 for compressed
  assign step = (instr.half[0][1:0] == ifu_pkg::FULL_OPC) ? 3'd4 : 3'd2;

  always_comb begin
    if (jump_en) begin
      next_pc = jump_addr;
    end else if (load) begin
      next_pc = pc + {{(ifu_pkg::ADDR_W-3){1'b0}}, step};
    end else begin
      // stalled on a miss or back-pressure
      next_pc = pc;
    end
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      pc <= RESET_ADDR;
    end else begin
      pc <= next_pc;
    end
  end

  // issue valid flag
  // jump clears, a transfer without reload empties
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      issue_valid <= 1'b0;
    end else if (jump_en) begin
      issue_valid <= 1'b0;
    end else if (load) begin
      issue_valid <= 1'b1;
    end else if (issue_ready) begin
      issue_valid <= 1'b0;
    end
  end

  // payload holds unless a new instruction loads
  always_ff @(posedge clk) begin
    if (load) begin
      issue_instr <= instr.word;
      issue_pc    <= pc;
    end
  end

endmodule

`default_nettype wire

// ==== src/prefetch_addr_gen.sv ====
`default_nettype none

module prefetch_addr_gen #(
  parameter int PREFETCH_NUM   = ifu_pkg::DEF_PREFETCH_NUM,
  parameter int INFLIGHT_DEPTH = ifu_pkg::DEF_INFLIGHT_DEPTH,
  parameter int LINE_DEPTH     = ifu_pkg::DEF_LINE_DEPTH
) (
  input  wire logic [ifu_pkg::ADDR_W-1:0]                       pc,
  input  wire logic [ifu_pkg::ADDR_W-1:0]                       next_pc,
  input  wire logic [1:0]                                       demand_req,
  input  wire logic                                             fifo_full,
  input  wire logic [INFLIGHT_DEPTH-1:0][ifu_pkg::WORD_ADDR_W-1:0] queued_tags,
  input  wire logic [INFLIGHT_DEPTH-1:0]                        queued_valid,
  input  wire logic [LINE_DEPTH-1:0][ifu_pkg::WORD_ADDR_W-1:0]  line_tags,
  input  wire logic [LINE_DEPTH-1:0]                            line_valid,
  output logic                                                  rd_req,
  output logic      [ifu_pkg::ADDR_W-1:0]                       rd_addr
);

  localparam int TW = ifu_pkg::WORD_ADDR_W;

  logic [PREFETCH_NUM-1:0][TW-1:0] pf_tag;
  logic [PREFETCH_NUM-1:0]         pf_held;
  logic [TW-1:0]                   pc_tag;
  logic [TW-1:0]                   sel_tag;
  logic                            pf_miss;

  assign pc_tag = pc[ifu_pkg::ADDR_W-1:2];

  // prefetch window starts at the word of next_pc
  // a word counts as held if buffered or already on the bus
  always_comb begin
    for (int i = 0; i < PREFETCH_NUM; i++) begin
      pf_tag[i]  = next_pc[ifu_pkg::ADDR_W-1:2] + TW'(i);
      pf_held[i] = 1'b0;
      for (int j = 0; j < INFLIGHT_DEPTH; j++) begin
        if (queued_valid[j] && (queued_tags[j] == pf_tag[i])) begin
          pf_held[i] = 1'b1;
        end
      end
      for (int j = 0; j < LINE_DEPTH; j++) begin
        if (line_valid[j] && (line_tags[j] == pf_tag[i])) begin
          pf_held[i] = 1'b1;
        end
      end
    end
  end

  always_comb begin
    sel_tag = pf_tag[0];
    pf_miss = 1'b0;
    // walk down so the nearest missing word wins
    for (int i = PREFETCH_NUM - 1; i >= 0; i--) begin
      if (!pf_held[i]) begin
        sel_tag = pf_tag[i];
        pf_miss = 1'b1;
      end
    end
    // assembler demands override prefetch, pc word first
    if (demand_req[0]) begin
      sel_tag = pc_tag;
    end else if (demand_req[1]) begin
      sel_tag = pc_tag + 1'b1;
    end
  end

  // no request while the queue cannot take the tag
  assign rd_req  = !fifo_full && (pf_miss || (demand_req != 2'b00));
  assign rd_addr = {sel_tag, 2'b00};

endmodule

`default_nettype wire

// ==== src/inflight_tag_fifo.sv ====
`default_nettype none

module inflight_tag_fifo #(
  parameter int DEPTH = ifu_pkg::DEF_INFLIGHT_DEPTH
) (
  input  wire logic                                  clk,
  input  wire logic                                  rest,
  input  wire logic                                  rd_req,
  input  wire logic                                  rd_ready,
  input  wire logic [ifu_pkg::ADDR_W-1:0]            rd_addr,
  input  wire logic                                  rd_data_valid,
  output logic      [ifu_pkg::WORD_ADDR_W-1:0]       head_tag,
  output logic                                       full,
  output logic      [DEPTH-1:0][ifu_pkg::WORD_ADDR_W-1:0] queued_tags,
  output logic      [DEPTH-1:0]                      queued_valid
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [PTR_W-1:0]                         wr_ptr;
  logic [PTR_W-1:0]                         rd_ptr;
  logic [CNT_W-1:0]                         count;
  logic [DEPTH-1:0][ifu_pkg::WORD_ADDR_W-1:0] tags_q;
  logic                                     push;
  logic                                     pop;

  // circular pointer step
  function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // push on bus acceptance, pop on each returned word
  assign push = rd_req && rd_ready && !full;
  assign pop  = rd_data_valid && (count != '0);
  assign full = (count == CNT_W'(DEPTH));

  // oldest outstanding read tags the arriving word
  assign head_tag    = tags_q[rd_ptr];
  assign queued_tags = tags_q;

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      queued_valid <= '0;
    end else begin
      if (pop) begin
        rd_ptr               <= bump(rd_ptr);
        queued_valid[rd_ptr] <= 1'b0;
      end
      // pointers only meet when empty or full, so no slot clash
      if (push) begin
        wr_ptr               <= bump(wr_ptr);
        queued_valid[wr_ptr] <= 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      tags_q[wr_ptr] <= rd_addr[ifu_pkg::ADDR_W-1:2];
    end
  end

endmodule

`default_nettype wire

// ==== src/fetch_line_buffer.sv ====
`default_nettype none

module fetch_line_buffer #(
  parameter int DEPTH = ifu_pkg::DEF_LINE_DEPTH
) (
  input  wire logic                                  clk,
  input  wire logic                                  rest,
  input  wire logic                                  rd_data_valid,
  input  wire logic [ifu_pkg::WORD_ADDR_W-1:0]       head_tag,
  input  wire logic [2*ifu_pkg::HALF_W-1:0]          rd_data,
  output logic      [DEPTH-1:0][ifu_pkg::WORD_ADDR_W-1:0] line_tags,
  output logic      [DEPTH-1:0]                      line_valid,
  output logic      [DEPTH-1:0][2*ifu_pkg::HALF_W-1:0] line_data
);

  // valid bits shift with the words
  // newest at index 0, oldest falls off the end
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      line_valid <= '0;
    end else if (rd_data_valid) begin
      line_valid[0] <= 1'b1;
      for (int i = 1; i < DEPTH; i++) begin
        line_valid[i] <= line_valid[i-1];
      end
    end
  end

  // tag and data move together
  always_ff @(posedge clk) begin
    if (rd_data_valid) begin
      line_tags[0] <= head_tag;
      line_data[0] <= rd_data;
      for (int i = 1; i < DEPTH; i++) begin
        line_tags[i] <= line_tags[i-1];
        line_data[i] <= line_data[i-1];
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/instr_assembler.sv ====
`default_nettype none

module instr_assembler #(
  parameter int INFLIGHT_DEPTH = ifu_pkg::DEF_INFLIGHT_DEPTH,
  parameter int LINE_DEPTH     = ifu_pkg::DEF_LINE_DEPTH
) (
  input  wire logic [ifu_pkg::ADDR_W-1:0]                       pc,
  input  wire logic [LINE_DEPTH-1:0][ifu_pkg::WORD_ADDR_W-1:0]  line_tags,
  input  wire logic [LINE_DEPTH-1:0]                            line_valid,
  input  wire logic [LINE_DEPTH-1:0][2*ifu_pkg::HALF_W-1:0]     line_data,
  input  wire logic                                             rd_data_valid,
  input  wire logic [ifu_pkg::WORD_ADDR_W-1:0]                  head_tag,
  input  wire logic [2*ifu_pkg::HALF_W-1:0]                     rd_data,
  input  wire logic [INFLIGHT_DEPTH-1:0][ifu_pkg::WORD_ADDR_W-1:0] queued_tags,
  input  wire logic [INFLIGHT_DEPTH-1:0]                        queued_valid,
  output logic                                                  instr_ok,
  output ifu_pkg::fetch_word_u                                  instr,
  output logic      [1:0]                                       demand_req
);

  localparam int TW    = ifu_pkg::WORD_ADDR_W;
  localparam int HIT_N = LINE_DEPTH + 1;

  logic [HIT_N-1:0][TW-1:0]        hit_tags;
  logic [HIT_N-1:0]                hit_valid;
  ifu_pkg::fetch_word_u [HIT_N-1:0] hit_data;
  logic [1:0][TW-1:0]              want_tag;
  logic [1:0]                      found;
  logic [1:0]                      queued;
  ifu_pkg::fetch_word_u [1:0]      word;
  logic [ifu_pkg::HALF_W-1:0]      lo_half;
  logic [ifu_pkg::HALF_W-1:0]      hi_half;
  logic                            is_full;
  logic                            need_next;

  // hit set is the buffer plus the word on the bus this cycle
  always_comb begin
    for (int i = 0; i < LINE_DEPTH; i++) begin
      hit_tags[i]      = line_tags[i];
      hit_valid[i]     = line_valid[i];
      hit_data[i].word = line_data[i];
    end
    hit_tags[LINE_DEPTH]      = head_tag;
    hit_valid[LINE_DEPTH]     = rd_data_valid;
    hit_data[LINE_DEPTH].word = rd_data;
  end

  // k=0 pc word, k=1 the word after
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      want_tag[k] = pc[ifu_pkg::ADDR_W-1:2] + TW'(k);
      found[k]    = 1'b0;
      queued[k]   = 1'b0;
      word[k]     = '0;
      // stale copies hold the same data, any match will do
      for (int i = HIT_N - 1; i >= 0; i--) begin
        if (hit_valid[i] && (hit_tags[i] == want_tag[k])) begin
          found[k] = 1'b1;
          word[k]  = hit_data[i];
        end
      end
      for (int j = 0; j < INFLIGHT_DEPTH; j++) begin
        if (queued_valid[j] && (queued_tags[j] == want_tag[k])) begin
          queued[k] = 1'b1;
        end
      end
    end
  end

  // pc bit 1 picks the half, upper half straddles into the next word
  assign lo_half   = pc[1] ? word[0].half[1] : word[0].half[0];
  assign hi_half   = pc[1] ? word[1].half[0] : word[0].half[1];
  assign is_full   = (lo_half[1:0] == ifu_pkg::FULL_OPC);
  assign need_next = is_full && pc[1];

  assign instr_ok = found[0] && (!need_next || found[1]);

  // compressed instruction zero extended to a word
  always_comb begin
    instr.half[0] = lo_half;
    instr.half[1] = is_full ? hi_half : '0;
  end

  // next word only known needed once the pc word is seen
  assign demand_req[0] = !found[0] && !queued[0];
  assign demand_req[1] = found[0] && need_next && !found[1] && !queued[1];

endmodule

`default_nettype wire

// ==== src/ifu_top.sv ====
`default_nettype none

module ifu_top #(
  parameter logic [ifu_pkg::ADDR_W-1:0] RESET_ADDR     = ifu_pkg::DEF_RESET_ADDR,
  parameter int                         PREFETCH_NUM   = ifu_pkg::DEF_PREFETCH_NUM,
  parameter int                         INFLIGHT_DEPTH = ifu_pkg::DEF_INFLIGHT_DEPTH,
  parameter int                         LINE_DEPTH     = ifu_pkg::DEF_LINE_DEPTH
) (
  input  wire logic                          clk,
  input  wire logic                          rest,
  input  wire logic                          jump_en,
  input  wire logic [ifu_pkg::ADDR_W-1:0]    jump_addr,
  output logic                               rd_req,
  output logic      [ifu_pkg::ADDR_W-1:0]    rd_addr,
  input  wire logic                          rd_ready,
  input  wire logic                          rd_data_valid,
  input  wire logic [2*ifu_pkg::HALF_W-1:0]  rd_data,
  output logic                               issue_valid,
  output logic      [2*ifu_pkg::HALF_W-1:0]  issue_instr,
  output logic      [ifu_pkg::ADDR_W-1:0]    issue_pc,
  input  wire logic                          issue_ready
);

  // pc side
  logic [ifu_pkg::ADDR_W-1:0] pc;
  logic [ifu_pkg::ADDR_W-1:0] next_pc;
  logic                       instr_ok;
  ifu_pkg::fetch_word_u       instr;
  logic [1:0]                 demand_req;

  // in-flight queue
  logic                                             fifo_full;
  logic [ifu_pkg::WORD_ADDR_W-1:0]                  head_tag;
  logic [INFLIGHT_DEPTH-1:0][ifu_pkg::WORD_ADDR_W-1:0] queued_tags;
  logic [INFLIGHT_DEPTH-1:0]                        queued_valid;

  // returned words
  logic [LINE_DEPTH-1:0][ifu_pkg::WORD_ADDR_W-1:0] line_tags;
  logic [LINE_DEPTH-1:0]                           line_valid;
  logic [LINE_DEPTH-1:0][2*ifu_pkg::HALF_W-1:0]    line_data;

  pc_sequencer #(
    .RESET_ADDR (RESET_ADDR)
  ) pc_seq_i (
    .clk         (clk),
    .rest        (rest),
    .jump_en     (jump_en),
    .jump_addr   (jump_addr),
    .instr_ok    (instr_ok),
    .instr       (instr),
    .issue_ready (issue_ready),
    .pc          (pc),
    .next_pc     (next_pc),
    .issue_valid (issue_valid),
    .issue_instr (issue_instr),
    .issue_pc    (issue_pc)
  );

  prefetch_addr_gen #(
    .PREFETCH_NUM   (PREFETCH_NUM),
    .INFLIGHT_DEPTH (INFLIGHT_DEPTH),
    .LINE_DEPTH     (LINE_DEPTH)
  ) pf_gen_i (
    .pc           (pc),
    .next_pc      (next_pc),
    .demand_req   (demand_req),
    .fifo_full    (fifo_full),
    .queued_tags  (queued_tags),
    .queued_valid (queued_valid),
    .line_tags    (line_tags),
    .line_valid   (line_valid),
    .rd_req       (rd_req),
    .rd_addr      (rd_addr)
  );

  inflight_tag_fifo #(
    .DEPTH (INFLIGHT_DEPTH)
  ) tag_fifo_i (
    .clk           (clk),
    .rest          (rest),
    .rd_req        (rd_req),
    .rd_ready      (rd_ready),
    .rd_addr       (rd_addr),
    .rd_data_valid (rd_data_valid),
    .head_tag      (head_tag),
    .full          (fifo_full),
    .queued_tags   (queued_tags),
    .queued_valid  (queued_valid)
  );

  fetch_line_buffer #(
    .DEPTH (LINE_DEPTH)
  ) line_buf_i (
    .clk           (clk),
    .rest          (rest),
    .rd_data_valid (rd_data_valid),
    .head_tag      (head_tag),
    .rd_data       (rd_data),
    .line_tags     (line_tags),
    .line_valid    (line_valid),
    .line_data     (line_data)
  );

  instr_assembler #(
    .INFLIGHT_DEPTH (INFLIGHT_DEPTH),
    .LINE_DEPTH     (LINE_DEPTH)
  ) asm_i (
    .pc            (pc),
    .line_tags     (line_tags),
    .line_valid    (line_valid),
    .line_data     (line_data),
    .rd_data_valid (rd_data_valid),
    .head_tag      (head_tag),
    .rd_data       (rd_data),
    .queued_tags   (queued_tags),
    .queued_valid  (queued_valid),
    .instr_ok      (instr_ok),
    .instr         (instr),
    .demand_req    (demand_req)
  );

endmodule

`default_nettype wire

// ==== dv/ifu_mem_model.sv ====
`default_nettype none

module ifu_mem_model (
  input  wire logic                       clk,
  input  wire logic                       rest,
  input  wire logic                       rd_req,
  input  wire logic [ifu_pkg::ADDR_W-1:0] rd_addr,
  output logic                            rd_ready,
  output logic                            rd_data_valid,
  output logic [2*ifu_pkg::HALF_W-1:0]    rd_data
);

  timeunit 1ns;
  timeprecision 1ps;

  // 256 byte image
  // upper address bits alias
  localparam int IMG_WORDS = 64;

  ifu_pkg::fetch_word_u image [IMG_WORDS];

  // accepted reads waiting for their answer
  // oldest at the front
  logic [5:0]  pend_idx [$];
  int unsigned pend_due [$];
  int unsigned cycle;
  // read taken on the last rising edge
  logic        acc_q;
  logic [5:0]  acc_idx;

  initial begin
    rd_ready      = 1'b0;
    rd_data_valid = 1'b0;
    rd_data       = '0;
  end

  // note a read taken on the rising edge
  always @(posedge clk or negedge rest) begin
    if (!rest) begin
      cycle = 0;
      acc_q = 1'b0;
    end else begin
      cycle++;
      acc_q   = rd_req && rd_ready;
      acc_idx = rd_addr[7:2];
    end
  end

  // outputs change on the falling edge
  // each read is due 0 to 4 cycles after it was taken
  // a late head blocks the younger reads so order is kept
  always @(negedge clk) begin
    if (!rest) begin
      pend_idx.delete();
      pend_due.delete();
    end else if (acc_q) begin
      pend_idx.push_back(acc_idx);
      pend_due.push_back(cycle + $urandom_range(4, 0));
    end
    rd_ready = ($urandom_range(3, 0) != 0);
    if (pend_idx.size() > 0 && pend_due[0] <= cycle) begin
      rd_data_valid = 1'b1;
      rd_data       = image[pend_idx.pop_front()].word;
      void'(pend_due.pop_front());
    end else begin
      rd_data_valid = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== dv/ifu_tb.sv ====
`default_nettype none

module ifu_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [ifu_pkg::ADDR_W-1:0] RESET_ADDR = ifu_pkg::DEF_RESET_ADDR;
  localparam int INFLIGHT_DEPTH = ifu_pkg::DEF_INFLIGHT_DEPTH;
  // cycles allowed per instruction
  // slack for reset and start-up
  localparam int CYC_PER_INSTR = 40;
  localparam int MARGIN        = 100;

  logic                           clk;
  logic                           rest;
  logic                           jump_en;
  logic [ifu_pkg::ADDR_W-1:0]     jump_addr;
  logic                           issue_ready;
  logic                           rd_req;
  logic [ifu_pkg::ADDR_W-1:0]     rd_addr;
  logic                           rd_ready;
  logic                           rd_data_valid;
  logic [2*ifu_pkg::HALF_W-1:0]   rd_data;
  logic                           issue_valid;
  logic [2*ifu_pkg::HALF_W-1:0]   issue_instr;
  logic [ifu_pkg::ADDR_W-1:0]     issue_pc;

  // reference walk state
  logic [ifu_pkg::ADDR_W-1:0]     ref_pc;
  logic [2*ifu_pkg::HALF_W-1:0]   exp_instr;
  logic                           first_xfer;
  logic                           rest_q;
  logic                           rest_qq;
  int                             xfers;
  int                             outstanding;
  int                             errors = 0;
  int                             tests = 0;
  bit                             timed_out = 1'b0;

  ifu_top #(
    .RESET_ADDR (RESET_ADDR)
  ) dut_i (
    .clk           (clk),
    .rest          (rest),
    .jump_en       (jump_en),
    .jump_addr     (jump_addr),
    .rd_req        (rd_req),
    .rd_addr       (rd_addr),
    .rd_ready      (rd_ready),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data),
    .issue_valid   (issue_valid),
    .issue_instr   (issue_instr),
    .issue_pc      (issue_pc),
    .issue_ready   (issue_ready)
  );

  ifu_mem_model mem_i (
    .clk           (clk),
    .rest          (rest),
    .rd_req        (rd_req),
    .rd_addr       (rd_addr),
    .rd_ready      (rd_ready),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // decode the image at pc
  // low opcode 11 also takes the next halfword
  // which may sit in the next word
  function automatic logic [31:0] decode_at(input logic [ifu_pkg::ADDR_W-1:0] pc);
    ifu_pkg::fetch_word_u w0;
    ifu_pkg::fetch_word_u w1;
    logic [15:0]          lo;
    logic [15:0]          hi;
    w0 = mem_i.image[pc[7:2]];
    w1 = mem_i.image[pc[7:2] + 6'd1];
    lo = w0.half[pc[1]];
    hi = pc[1] ? w1.half[0] : w0.half[1];
    if (lo[1:0] == ifu_pkg::FULL_OPC) begin
      return {hi, lo};
    end
    return {16'h0000, lo};
  endfunction

  // every word a 32-bit instruction
  task automatic fill_full_words();
    logic [31:0] r;
    for (int i = 0; i < 64; i++) begin
      r = $urandom();
      mem_i.image[i].word = {r[31:2], 2'b11};
    end
  endtask

  // random stream of 16 and 32-bit instructions at halfword granularity
  task automatic fill_mixed();
    logic [15:0] halves [128];
    logic [31:0] r;
    int          h;
    h = 0;
    while (h < 128) begin
      r = $urandom();
      if (h < 127 && r[18]) begin
        halves[h]     = {r[15:2], 2'b11};
        halves[h + 1] = r[31:16];
        h += 2;
      end else begin
        halves[h] = {r[15:2], (r[17:16] == 2'b11) ? 2'b01 : r[17:16]};
        h += 1;
      end
    end
    for (int i = 0; i < 64; i++) begin
      mem_i.image[i].word = {halves[2*i + 1], halves[2*i]};
    end
  endtask

  // checks on the rising edge where inputs are stable
  always @(posedge clk) begin
    if (!rest) begin
      assert (!issue_valid) else begin
        $display("Error: issue_valid in reset expected 0x0 got 0x%h", issue_valid);
        errors++;
      end
      ref_pc      = RESET_ADDR;
      first_xfer  = 1'b1;
      outstanding = 0;
    end else begin
      // one active edge after release, nothing can be issued yet
      if (rest_q && !rest_qq) begin
        assert (!issue_valid) else begin
          $display("Error: issue_valid after release expected 0x0 got 0x%h", issue_valid);
          errors++;
        end
      end
      if (issue_valid && issue_ready) begin
        exp_instr = decode_at(ref_pc);
        if (first_xfer) begin
          assert (issue_pc == RESET_ADDR) else begin
            $display("Error: issue_pc first expected 0x%h got 0x%h", RESET_ADDR, issue_pc);
            errors++;
          end
        end
        assert (issue_pc == ref_pc) else begin
          $display("Error: issue_pc expected 0x%h got 0x%h", ref_pc, issue_pc);
          errors++;
        end
        assert (issue_instr == exp_instr) else begin
          $display("Error: issue_instr at 0x%h expected 0x%h got 0x%h",
                   ref_pc, exp_instr, issue_instr);
          errors++;
        end
        ref_pc     = ref_pc + ((exp_instr[1:0] == ifu_pkg::FULL_OPC) ? 32'd4 : 32'd2);
        first_xfer = 1'b0;
        xfers++;
      end
      // a transfer on this edge counts before the walk restarts
      if (jump_en) begin
        ref_pc     = jump_addr;
        first_xfer = 1'b0;
      end
      if (rd_req && rd_ready) begin
        outstanding++;
      end
      if (rd_data_valid) begin
        outstanding--;
      end
      assert (outstanding <= INFLIGHT_DEPTH) else begin
        $display("Error: outstanding reads expected at most 0x%h got 0x%h",
                 INFLIGHT_DEPTH, outstanding);
        errors++;
      end
    end
    rest_qq = rest_q;
    rest_q  = rest;
  end

  // payload frozen while the downstream stage stalls
  hold_check: assert property (@(posedge clk) disable iff (!rest)
    (issue_valid && !issue_ready && !jump_en) |=>
      (issue_valid && $stable(issue_instr) && $stable(issue_pc)))
    else begin
      $display("Error: issue payload moved under back-pressure, issue_pc 0x%h issue_instr 0x%h",
               issue_pc, issue_instr);
      errors++;
    end

  // reset and load an image
  // then run until n_instr transfers or the cycle limit
  task automatic run_test(input string name, input int n_instr, input bit full_only,
                          input bit rand_ready, input bit do_jumps);
    int base_err;
    int cycles;
    int limit;
    base_err = errors;
    limit    = CYC_PER_INSTR * n_instr + MARGIN;
    cycles   = 0;
    if (!timed_out) begin
      @(negedge clk);
      rest        = 1'b0;
      jump_en     = 1'b0;
      issue_ready = 1'b0;
      if (full_only) begin
        fill_full_words();
      end else begin
        fill_mixed();
      end
      repeat (5) @(negedge clk);
      xfers = 0;
      rest  = 1'b1;
      while (xfers < n_instr && cycles < limit) begin
        @(negedge clk);
        issue_ready = rand_ready ? ($urandom_range(1, 0) == 1) : 1'b1;
        // single-cycle jump pulses never back to back
        jump_en     = do_jumps && !jump_en && ($urandom_range(15, 0) == 0);
        jump_addr   = {24'h000000, 7'($urandom_range(127, 0)), 1'b0};
        cycles++;
      end
      @(negedge clk);
      jump_en     = 1'b0;
      issue_ready = 1'b0;
      tests++;
      if (xfers < n_instr) begin
        timed_out = 1'b1;
        $display("test %s timed out after %0d cycles with %0d of %0d instructions",
                 name, cycles, xfers, n_instr);
      end else begin
        $display("test %s done, %0d instructions, %0d errors", name, xfers, errors - base_err);
      end
    end
  endtask

  initial begin
    void'($urandom(99));
    rest        = 1'b0;
    jump_en     = 1'b0;
    jump_addr   = '0;
    issue_ready = 1'b0;
    rest_q      = 1'b0;
    rest_qq     = 1'b0;
    run_test("reset", 8, 1'b1, 1'b0, 1'b0);
    run_test("full_words", 24, 1'b1, 1'b0, 1'b0);
    run_test("mixed", 40, 1'b0, 1'b0, 1'b0);
    run_test("backpressure", 40, 1'b0, 1'b1, 1'b0);
    run_test("jump", 40, 1'b0, 1'b1, 1'b1);
    run_test("latency", 64, 1'b0, 1'b1, 1'b1);
    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0 && !timed_out) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== ifu.f ====
src/ifu_pkg.sv
src/pc_sequencer.sv
src/prefetch_addr_gen.sv
src/inflight_tag_fifo.sv
src/fetch_line_buffer.sv
src/instr_assembler.sv
src/ifu_top.sv
dv/ifu_mem_model.sv
dv/ifu_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps
SIM_FLAGS  ?= --binary --timing --assert --timescale 1ns/1ps
TOP        ?= ifu_tb
FILELIST   ?= ifu.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
